/* Makefile */
TOP = upCoreTb

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --timescale 1ns/10ps \
		--top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* source/upCore.sv */
`timescale 1ns/10ps
`default_nettype none

module upCore import upPkg::*; (
	input wire clk,
	input wire nRst,
	input wire loadEn,
	input wire [7:0] loadAddr,
	input wire [7:0] loadData,
	output logic [7:0] testByte,
	output logic [7:0] acc,
	output logic halted
);

	memReq_t memReq;
	logic [7:0] rdData;
	instr_u instr;
	logic [7:0] operand;
	decoded_t decoded;
	execOut_t result;
	logic [7:0] pc;
	flags_t flags;
	logic commit;
	logic restart;

	upSequencer sequencer (
		.clk(clk),
		.nRst(nRst),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.pc(pc),
		.acc(acc),
		.rdData(rdData),
		.decoded(decoded),
		.halted(halted),
		.instr(instr),
		.operand(operand),
		.memReq(memReq),
		.commit(commit),
		.restart(restart)
	);

	upDecode decode (
		.instr(instr),
		.decoded(decoded)
	);

	upExecute execute (
		.decoded(decoded),
		.operand(operand),
		.rdData(rdData),
		.acc(acc),
		.flags(flags),
		.result(result)
	);

	upResult resultRegs (
		.clk(clk),
		.nRst(nRst),
		.commit(commit),
		.restart(restart),
		.result(result),
		.pc(pc),
		.acc(acc),
		.flags(flags),
		.halted(halted)
	);

	upMemory memory (
		.clk(clk),
		.nRst(nRst),
		.memReq(memReq),
		.rdData(rdData),
		.testByte(testByte)
	);

endmodule

`default_nettype wire

/* source/upDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module upDecode import upPkg::*; (
	input wire instr_u instr,
	output decoded_t decoded
);

	// The class field sits at the same bits in both views.
	always_comb begin
		decoded = '0;
		case (instr.aluForm.cls)
			classAlu: begin
				if (instr.aluForm.aluOp == opStore) begin
					decoded.isStore = !instr.aluForm.immediate;	// Store #imm is a nop.
				end else if (instr.aluForm.aluOp <= opXor) begin
					decoded.isAlu = 1'b1;
					decoded.aluOp = instr.aluForm.aluOp;
					decoded.immediate = instr.aluForm.immediate;
				end
			end
			classBranch: begin
				decoded.isBranch = 1'b1;
				decoded.cond = instr.branchForm.cond;
			end
			classHalt: begin
				decoded.isHalt = 1'b1;
			end
			default: begin
				decoded = '0;	// Reserved class.
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/upExecute.sv */
`timescale 1ns/10ps
`default_nettype none

module upExecute import upPkg::*; (
	input wire decoded_t decoded,
	input wire [7:0] operand,
	input wire [7:0] rdData,
	input wire [7:0] acc,
	input wire flags_t flags,
	output execOut_t result
);

	logic [7:0] srcB;
	logic [8:0] sum;
	logic condMet;

	assign srcB = decoded.immediate ? operand : rdData;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		sum = {1'b0, acc};
		case (decoded.aluOp)
			opLoad: sum = {flags.carry, srcB};	// Carry passes through.
			opAdd: sum = {1'b0, acc} + {1'b0, srcB};
			opSub: sum = {1'b0, acc} - {1'b0, srcB};	// Bit 8 is the borrow.
			opAnd: sum = {1'b0, acc & srcB};
			opOr: sum = {1'b0, acc | srcB};
			opXor: sum = {1'b0, acc ^ srcB};
			default: sum = {flags.carry, acc};
		endcase
	end

	always_comb begin
		case (decoded.cond)
			condAlways: condMet = 1'b1;
			condZero: condMet = flags.zero;
			condCarry: condMet = flags.carry;
			default: condMet = flags.negative;
		endcase
	end

	always_comb begin
		result = '0;
		result.value = sum[7:0];
		result.newFlags.zero = (sum[7:0] == 8'd0);
		result.newFlags.carry = sum[8];
		result.newFlags.negative = sum[7];
		result.writeAcc = decoded.isAlu;
		result.writeFlags = decoded.isAlu;
		result.takeBranch = decoded.isBranch && condMet;
		result.doStore = decoded.isStore;
		result.doHalt = decoded.isHalt;
		result.target = operand;
	end

endmodule

`default_nettype wire

/* source/upMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module upMemory import upPkg::*; (
	input wire clk,
	input wire nRst,
	input wire memReq_t memReq,
	output logic [7:0] rdData,
	output logic [7:0] testByte
);

	logic [7:0] mem [0:255];

	assign rdData = mem[memReq.addr];	// Asynchronous read.
	assign testByte = mem[testAddr];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= bootImage[i];
			end
		end else if (memReq.we) begin
			mem[memReq.addr] <= memReq.data;
		end
	end

endmodule

`default_nettype wire

/* source/upPkg.sv */
`default_nettype none

package upPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction byte
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [1:0] cls;
		logic [2:0] aluOp;
		logic immediate;	// Operand is the byte itself.
		logic [1:0] spare;
	} aluForm_t;

	typedef struct packed {
		logic [1:0] cls;
		logic [1:0] cond;
		logic [3:0] spare;
	} branchForm_t;

	typedef union packed {
		aluForm_t aluForm;
		branchForm_t branchForm;
	} instr_u;

	localparam logic [1:0] classAlu = 2'b00;
	localparam logic [1:0] classBranch = 2'b01;
	localparam logic [1:0] classHalt = 2'b11;

	localparam logic [2:0] opLoad = 3'd0;
	localparam logic [2:0] opAdd = 3'd1;
	localparam logic [2:0] opSub = 3'd2;
	localparam logic [2:0] opAnd = 3'd3;
	localparam logic [2:0] opOr = 3'd4;
	localparam logic [2:0] opXor = 3'd5;
	localparam logic [2:0] opStore = 3'd6;

	localparam logic [1:0] condAlways = 2'd0;
	localparam logic [1:0] condZero = 2'd1;
	localparam logic [1:0] condCarry = 2'd2;
	localparam logic [1:0] condNegative = 2'd3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Internal buses
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		phaseFetch,
		phaseOperand,
		phaseExecute
	} phase_t;

	typedef struct packed {
		logic isAlu;	// Writes acc and flags.
		logic [2:0] aluOp;
		logic immediate;
		logic isStore;
		logic isBranch;
		logic [1:0] cond;
		logic isHalt;
	} decoded_t;

	typedef struct packed {
		logic zero;
		logic carry;
		logic negative;
	} flags_t;

	typedef struct packed {
		logic [7:0] value;
		flags_t newFlags;
		logic writeAcc;
		logic writeFlags;
		logic takeBranch;
		logic doStore;
		logic doHalt;
		logic [7:0] target;
	} execOut_t;

	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] data;
		logic we;
	} memReq_t;

	localparam logic [7:0] testAddr = 8'd96;

	// load #5, add #3, store 96, halt.
	localparam logic [7:0] bootImage [0:255] = '{
		0: 8'h04,
		1: 8'h05,
		2: 8'h0C,
		3: 8'h03,
		4: 8'h30,
		5: 8'h60,
		6: 8'hC0,
		7: 8'h00,
		default: 8'h00
	};

endpackage

`default_nettype wire

/* source/upResult.sv */
`timescale 1ns/10ps
`default_nettype none

module upResult import upPkg::*; (
	input wire clk,
	input wire nRst,
	input wire commit,
	input wire restart,
	input wire execOut_t result,
	output logic [7:0] pc,
	output logic [7:0] acc,
	output flags_t flags,
	output logic halted
);

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= 8'd0;
			acc <= 8'd0;
			flags <= '0;
			halted <= 1'b0;
		end else if (restart) begin
			pc <= 8'd0;	// Loader restarts the program.
			acc <= 8'd0;
			flags <= '0;
			halted <= 1'b0;
		end else if (commit) begin
			if (result.writeAcc) begin
				acc <= result.value;
			end
			if (result.writeFlags) begin
				flags <= result.newFlags;
			end
			if (result.doHalt) begin
				halted <= 1'b1;	// pc holds on halt.
			end else if (result.takeBranch) begin
				pc <= result.target;
			end else begin
				pc <= pc + 8'd2;
			end
		end
	end

endmodule

`default_nettype wire

/* source/upSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module upSequencer import upPkg::*; (
	input wire clk,
	input wire nRst,
	input wire loadEn,
	input wire [7:0] loadAddr,
	input wire [7:0] loadData,
	input wire [7:0] pc,
	input wire [7:0] acc,
	input wire [7:0] rdData,
	input wire decoded_t decoded,
	input wire halted,
	output instr_u instr,
	output logic [7:0] operand,
	output memReq_t memReq,
	output logic commit,
	output logic restart
);

	phase_t phase;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			phase <= phaseFetch;
		end else if (loadEn) begin
			phase <= phaseFetch;
		end else begin
			case (phase)
				phaseFetch: if (!halted) phase <= phaseOperand;	// Frozen when halted.
				phaseOperand: phase <= phaseExecute;
				default: phase <= phaseFetch;
			endcase
		end
	end

	// Opcode and operand latches.
	always_ff @(posedge clk) begin
		if (phase == phaseFetch) begin
			instr <= instr_u'(rdData);
		end
		if (phase == phaseOperand) begin
			operand <= rdData;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		memReq.addr = pc;
		memReq.data = acc;
		memReq.we = 1'b0;
		if (loadEn) begin
			memReq.addr = loadAddr;	// Loader overrides the core.
			memReq.data = loadData;
			memReq.we = 1'b1;
		end else begin
			case (phase)
				phaseOperand: memReq.addr = pc + 8'd1;
				phaseExecute: begin
					memReq.addr = operand;
					memReq.we = decoded.isStore;
				end
				default: memReq.addr = pc;
			endcase
		end
	end

	assign commit = (phase == phaseExecute);
	assign restart = loadEn;

endmodule

`default_nettype wire

/* test/upCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module upCoreTb import upPkg::*; ();

	localparam int testCount = 5;
	localparam int cyclesPerTest = 200;
	localparam int clockPeriod = 20;
	localparam logic [7:0] haltInstr = {classHalt, 6'd0};

	logic clk;
	logic nRst;
	logic loadEn;
	logic [7:0] loadAddr;
	logic [7:0] loadData;
	logic [7:0] testByte;
	logic [7:0] acc;
	logic halted;
	logic [31:0] lfsrState;
	logic [7:0] progBytes [$];

	upCore DUT (
		.clk(clk),
		.nRst(nRst),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.testByte(testByte),
		.acc(acc),
		.halted(halted)
	);

	bind upSequencer upSequencer_properties props (
		.clk(clk),
		.nRst(nRst),
		.loadEn(loadEn),
		.halted(halted),
		.restart(restart),
		.commit(commit),
		.phase(phase),
		.instr(instr),
		.memReq(memReq)
	);

	always #(clockPeriod / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] randomByte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsrState = lfsrNext(lfsrState);
			b = {b[6:0], lfsrState[0]};
		end
		return b;
	endfunction

	// Returns {carry, value}.
	function automatic logic [8:0] aluRef(input logic [2:0] op, input logic [7:0] a,
			input logic [7:0] b, input logic carryIn);
		case (op)
			opLoad: return {carryIn, b};
			opAdd: return {1'b0, a} + {1'b0, b};
			opSub: return {a < b, a - b};	// Borrow sets carry.
			opAnd: return {1'b0, a & b};
			opOr: return {1'b0, a | b};
			default: return {1'b0, a ^ b};
		endcase
	endfunction

	function automatic logic condRef(input logic [1:0] cond, input logic [8:0] r);
		case (cond)
			condAlways: return 1'b1;
			condZero: return r[7:0] == 8'd0;
			condCarry: return r[8];
			default: return r[7];
		endcase
	endfunction

	function automatic logic [7:0] aluInstr(input logic [2:0] op, input logic imm);
		return {classAlu, op, imm, 2'b00};
	endfunction

	function automatic logic [7:0] branchInstr(input logic [1:0] cond);
		return {classBranch, cond, 4'b0000};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Driving and checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic checkByte(input string testName, input logic [7:0] expected,
			input logic [7:0] actual);
		assert (actual === expected) else
			failRun($sformatf("mismatch %s expected %02h actual %02h",
				testName, expected, actual));
	endtask

	task automatic pokeByte(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		loadEn <= 1'b1;
		loadAddr <= addr;
		loadData <= data;
	endtask

	task automatic addInstr(input logic [7:0] opcode, input logic [7:0] arg);
		progBytes.push_back(opcode);
		progBytes.push_back(arg);
	endtask

	task automatic loadProgram();
		for (int i = 0; i < progBytes.size(); i++) begin
			pokeByte(8'(i), progBytes[i]);
			@(negedge clk);
			if (i > 0) begin	// Cleared by the first loader edge.
				assert (!halted) else failRun("halted was high while loading");
			end
		end
		@(posedge clk);
		loadEn <= 1'b0;
		progBytes.delete();
	endtask

	task automatic waitHalt(input string testName);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert (cycles <= cyclesPerTest) else
				failRun($sformatf("%s did not halt within %0d cycles",
					testName, cyclesPerTest));
		end while (!halted);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic bootTest();
		waitHalt("boot");
		checkByte("boot testByte", 8'd8, testByte);
		checkByte("boot acc", 8'd8, acc);
	endtask

	task automatic aluImmediateTest();
		logic [7:0] a;
		logic [7:0] b;
		logic [8:0] r;
		for (int op = 0; op <= 5; op++) begin
			a = randomByte();
			b = randomByte();
			r = aluRef(3'(op), a, b, 1'b0);
			addInstr(aluInstr(opLoad, 1'b1), a);
			addInstr(aluInstr(3'(op), 1'b1), b);
			addInstr(aluInstr(opStore, 1'b0), testAddr);
			addInstr(haltInstr, 8'h00);
			loadProgram();
			waitHalt("alu immediate");
			checkByte($sformatf("alu op %0d testByte", op), r[7:0], testByte);
			checkByte($sformatf("alu op %0d acc", op), r[7:0], acc);
		end
	endtask

	task automatic memoryOperandTest();
		logic [7:0] x;
		logic [7:0] y;
		x = randomByte();
		y = randomByte();
		pokeByte(8'd200, x);
		pokeByte(8'd201, y);
		addInstr(aluInstr(opLoad, 1'b0), 8'd200);
		addInstr(aluInstr(opAdd, 1'b0), 8'd201);
		addInstr(aluInstr(opStore, 1'b0), testAddr);
		addInstr(haltInstr, 8'h00);
		loadProgram();
		waitHalt("memory operand");
		checkByte("memory operand sum", 8'(aluRef(opAdd, x, y, 1'b0)), testByte);
		pokeByte(testAddr, 8'hA5);
		addInstr(aluInstr(opLoad, 1'b1), 8'h3C);
		addInstr(aluInstr(opStore, 1'b1), testAddr);	// Decodes as a nop.
		addInstr(haltInstr, 8'h00);
		loadProgram();
		waitHalt("store immediate");
		checkByte("store immediate", 8'hA5, testByte);
	endtask

	task automatic branchCase(input logic [1:0] cond, input logic [2:0] op,
			input logic [7:0] a, input logic [7:0] b);
		logic [7:0] expected;
		expected = condRef(cond, aluRef(op, a, b, 1'b0)) ? 8'h22 : 8'h11;
		addInstr(aluInstr(opLoad, 1'b1), a);
		addInstr(aluInstr(op, 1'b1), b);
		addInstr(branchInstr(cond), 8'd10);
		addInstr(aluInstr(opLoad, 1'b1), 8'h11);
		addInstr(branchInstr(condAlways), 8'd12);
		addInstr(aluInstr(opLoad, 1'b1), 8'h22);
		addInstr(aluInstr(opStore, 1'b0), testAddr);
		addInstr(haltInstr, 8'h00);
		loadProgram();
		waitHalt("branch");
		checkByte($sformatf("branch cond %0d op %0d", cond, op), expected, testByte);
	endtask

	task automatic branchTest();
		logic [7:0] x;
		for (int c = 0; c < 4; c++) begin
			x = randomByte();
			branchCase(2'(c), opSub, x, x);	// Zero, no carry.
			branchCase(2'(c), opAdd, 8'hFF, 8'h81);	// Carry and negative.
		end
		// Countdown from 5, counting passes at byte 96.
		pokeByte(testAddr, 8'h00);
		addInstr(aluInstr(opLoad, 1'b1), 8'd5);
		addInstr(aluInstr(opStore, 1'b0), testAddr + 8'd1);
		addInstr(aluInstr(opLoad, 1'b0), testAddr);
		addInstr(aluInstr(opAdd, 1'b1), 8'd1);
		addInstr(aluInstr(opStore, 1'b0), testAddr);
		addInstr(aluInstr(opLoad, 1'b0), testAddr + 8'd1);
		addInstr(aluInstr(opSub, 1'b1), 8'd1);
		addInstr(branchInstr(condZero), 8'd18);
		addInstr(branchInstr(condAlways), 8'd2);
		addInstr(haltInstr, 8'h00);
		loadProgram();
		waitHalt("countdown");
		checkByte("countdown count", 8'd5, testByte);
		checkByte("countdown acc", 8'd0, acc);
	endtask

	task automatic restartTest();
		logic [7:0] a;
		logic [7:0] b;
		a = randomByte();
		b = randomByte();
		addInstr(aluInstr(opAdd, 1'b1), 8'd1);	// Endless loop.
		addInstr(branchInstr(condAlways), 8'd0);
		loadProgram();
		repeat (30) @(posedge clk);
		addInstr(aluInstr(opLoad, 1'b1), a);
		addInstr(aluInstr(opXor, 1'b1), b);
		addInstr(aluInstr(opStore, 1'b0), testAddr);
		addInstr(haltInstr, 8'h00);
		loadProgram();
		waitHalt("restart");
		checkByte("restart result", 8'(aluRef(opXor, a, b, 1'b0)), testByte);
	endtask

	initial begin
		#(testCount * cyclesPerTest * clockPeriod);
		failRun("timeout: the tests did not finish in time");
	end

	initial begin
		clk = 1'b0;
		nRst = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		lfsrState = 32'h856c_0810;
		repeat (2) @(posedge clk);
		nRst <= 1'b1;
		bootTest();
		aluImmediateTest();
		memoryOperandTest();
		branchTest();
		restartTest();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/upSequencer_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module upSequencer_properties import upPkg::*; (
	input wire clk,
	input wire nRst,
	input wire loadEn,
	input wire halted,
	input wire restart,
	input wire commit,
	input wire phase_t phase,
	input wire instr_u instr,
	input wire memReq_t memReq
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Phase order
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	fetchToOperand: assert property (@(posedge clk) disable iff (!nRst)
		phase == phaseFetch && !halted && !loadEn |=> phase == phaseOperand)
		else $error("phase did not advance from fetch to operand");

	operandToExecute: assert property (@(posedge clk) disable iff (!nRst)
		phase == phaseOperand && !loadEn |=> phase == phaseExecute)
		else $error("phase did not advance from operand to execute");

	executeToFetch: assert property (@(posedge clk) disable iff (!nRst)
		phase == phaseExecute |=> phase == phaseFetch)
		else $error("phase did not return to fetch after execute");

	// Writes come from the loader or a store.
	writeSource: assert property (@(posedge clk) disable iff (!nRst)
		memReq.we |-> loadEn || (phase == phaseExecute
			&& instr.aluForm.cls == classAlu && instr.aluForm.aluOp == opStore
			&& !instr.aluForm.immediate))
		else $error("memory write outside a store or a load");

	haltHolds: assert property (@(posedge clk) disable iff (!nRst)
		halted && !restart |=> halted)
		else $error("halted dropped without a restart");

	// Execute follows an operand cycle without the loader.
	commitInExecute: assert property (@(posedge clk) disable iff (!nRst)
		commit |-> $past(phase) == phaseOperand && !$past(loadEn))
		else $error("commit raised outside the execute phase");

endmodule

`default_nettype wire

/* verilog.f */
source/upPkg.sv
source/upMemory.sv
source/upDecode.sv
source/upExecute.sv
source/upResult.sv
source/upSequencer.sv
source/upCore.sv
test/upSequencer_properties.sv
test/upCoreTb.sv
